/* verilog/mem_pkg.sv */
package mem_pkg;

	////////////////////
	// Widths
	////////////////////

	// External SRAM is 256K words of 16 bits
	localparam int ADDR_W = 18;
	localparam int DATA_W = 16;

	// Access tag, compared against the last tag served
	localparam int TAG_W = 8;

	typedef logic [ADDR_W-1:0] mem_addr_t;
	typedef logic [DATA_W-1:0] mem_word_t;
	typedef logic [TAG_W-1:0]  act_tag_t;

	////////////////////
	// Request and pins
	////////////////////

	// One client's level request toward the controller
	typedef struct packed {
		logic      need;
		logic      rd;
		logic      wr;
		mem_addr_t addr;
		mem_word_t wdata;
		act_tag_t  act;
	} mem_req_t;

	// Pins driven toward the SRAM, strobes active low
	typedef struct packed {
		mem_addr_t addr;
		mem_word_t data_out;
		logic      data_oe;
		logic      oe_n;
		logic      we_n;
		logic      en_n;
	} sram_bus_t;

endpackage

/* verilog/fetch_queue.sv */
`timescale 1ns/1ps

module fetch_queue import mem_pkg::*; #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic      clk,
	input  logic      rst,
	input  logic      push,
	input  mem_word_t push_data,
	input  logic      pop,
	output mem_word_t head,
	output logic      empty,
	output logic      full
);

	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam logic [PTR_W:0] FULL_CNT = (PTR_W + 1)'(QUEUE_DEPTH);

	mem_word_t        mem [QUEUE_DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W:0]   count;
	logic             do_push;
	logic             do_pop;

	assign empty = (count == '0);
	assign full  = (count == FULL_CNT);

	// Pop on empty or push on full is dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign head = mem[rd_ptr];

	////////////////////
	// Pointers
	////////////////////

	// Depth is a power of two so pointers wrap on their own
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

endmodule

/* verilog/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit import mem_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      fetch_done,
	input  mem_word_t fetch_rdata,
	input  logic      full,
	output mem_req_t  fetch_req,
	output logic      push,
	output mem_word_t push_data
);

	mem_addr_t pc;
	act_tag_t  tag;
	logic      room;

	////////////////////
	// Request
	////////////////////

	// The push in flight has not reached the queue count yet,
	// so hold off one clock after each push
	assign room = !full && !push;

	always_comb begin
		fetch_req.need  = room;
		fetch_req.rd    = 1'b1;
		fetch_req.wr    = 1'b0;
		fetch_req.addr  = pc;
		fetch_req.wdata = '0;
		fetch_req.act   = tag;
	end

	////////////////////
	// PC and tag
	////////////////////

	// Done drops as soon as the tag moves on, so one push per fetch
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pc   <= '0;
			tag  <= act_tag_t'(1);
			push <= 1'b0;
		end else begin
			push <= fetch_done;
			if (fetch_done) begin
				pc  <= pc + 1'b1;
				tag <= tag + 1'b1;
			end
		end
	end

	// Word handed to the queue along with push
	always_ff @(posedge clk) begin
		if (fetch_done) begin
			push_data <= fetch_rdata;
		end
	end

endmodule

/* verilog/sram_ctrl.sv */
`timescale 1ns/1ps

module sram_ctrl import mem_pkg::*; #(
	parameter int STEP_LOG2 = 1
) (
	input  logic      clk,
	input  logic      rst,
	input  mem_req_t  exe_req,
	input  mem_req_t  fetch_req,
	input  mem_word_t sram_data_in,
	output sram_bus_t sram,
	output logic      exe_done,
	output logic      fetch_done,
	output mem_word_t exe_rdata,
	output mem_word_t fetch_rdata
);

	////////////////////
	// State encoding
	////////////////////

	localparam logic [3:0] ST_IDLE = 4'd0;
	localparam logic [3:0] ST_RD1  = 4'd1;
	localparam logic [3:0] ST_RD2  = 4'd2;
	localparam logic [3:0] ST_RD3  = 4'd3;
	localparam logic [3:0] ST_WR1  = 4'd4;
	localparam logic [3:0] ST_WR2  = 4'd5;
	localparam logic [3:0] ST_WR3  = 4'd6;
	localparam logic [3:0] ST_FR1  = 4'd7;
	localparam logic [3:0] ST_FR2  = 4'd8;
	localparam logic [3:0] ST_FR3  = 4'd9;

	logic [3:0]           state;
	logic [3:0]           next_state;
	logic [STEP_LOG2-1:0] step_cnt;
	logic                 step_tick;
	act_tag_t             served_act;
	logic                 exe_done_r;
	logic                 fetch_done_r;
	logic                 exe_new;
	logic                 fetch_new;
	logic                 in_fetch;

	// Divider, one step per wrap
	assign step_tick = &step_cnt;

	// A request counts only once per tag
	assign exe_new   = exe_req.need && (exe_req.act != served_act);
	assign fetch_new = fetch_req.need && (fetch_req.act != served_act);

	// Done flags are stale once the requester moves to a new tag
	assign exe_done   = exe_done_r && (exe_req.act == served_act);
	assign fetch_done = fetch_done_r && (fetch_req.act == served_act);

	assign in_fetch = (state == ST_FR1) || (state == ST_FR2) || (state == ST_FR3);

	////////////////////
	// Next state
	////////////////////

	always_comb begin
		next_state = ST_IDLE;
		case (state)
			ST_IDLE: begin
				// Execute wins over fetch, reads before writes
				if (exe_new && exe_req.rd) begin
					next_state = ST_RD1;
				end else if (exe_new && exe_req.wr) begin
					next_state = ST_WR1;
				end else if (fetch_new) begin
					next_state = ST_FR1;
				end
			end
			ST_RD1:  next_state = ST_RD2;
			ST_RD2:  next_state = ST_RD3;
			ST_WR1:  next_state = ST_WR2;
			ST_WR2:  next_state = ST_WR3;
			ST_FR1:  next_state = ST_FR2;
			ST_FR2:  next_state = ST_FR3;
			default: next_state = ST_IDLE;
		endcase
	end

	////////////////////
	// Control state
	////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			step_cnt     <= '0;
			state        <= ST_IDLE;
			served_act   <= '0;
			exe_done_r   <= 1'b0;
			fetch_done_r <= 1'b0;
		end else begin
			step_cnt <= step_cnt + 1'b1;
			if (step_tick) begin
				state <= next_state;
				case (state)
					ST_IDLE: begin
						// New access drops the client's old done flag
						if (next_state == ST_RD1 || next_state == ST_WR1) begin
							exe_done_r <= 1'b0;
						end
						if (next_state == ST_FR1) begin
							fetch_done_r <= 1'b0;
						end
					end
					ST_RD3, ST_WR3: begin
						exe_done_r <= 1'b1;
						served_act <= exe_req.act;
					end
					ST_FR3: begin
						fetch_done_r <= 1'b1;
						served_act   <= fetch_req.act;
					end
					default: ;
				endcase
			end
		end
	end

	// Read data captured at the end of the third step
	always_ff @(posedge clk) begin
		if (step_tick && state == ST_RD3) begin
			exe_rdata <= sram_data_in;
		end
		if (step_tick && state == ST_FR3) begin
			fetch_rdata <= sram_data_in;
		end
	end

	////////////////////
	// Pin decode
	////////////////////

	always_comb begin
		// Fetch keeps its own address even while execute holds need
		if (in_fetch) begin
			sram.addr = fetch_req.addr;
		end else if (exe_req.need) begin
			sram.addr = exe_req.addr;
		end else begin
			sram.addr = fetch_req.addr;
		end
		sram.data_out = exe_req.wdata;
		sram.data_oe  = 1'b0;
		sram.oe_n     = 1'b1;
		sram.we_n     = 1'b1;
		sram.en_n     = 1'b1;
		case (state)
			ST_RD1, ST_FR1: begin
				sram.en_n = 1'b0;
			end
			ST_RD2, ST_RD3, ST_FR2, ST_FR3: begin
				sram.en_n = 1'b0;
				sram.oe_n = 1'b0;
			end
			ST_WR1: begin
				sram.en_n    = 1'b0;
				sram.data_oe = 1'b1;
			end
			ST_WR2, ST_WR3: begin
				// Data already stable from the first step
				sram.en_n    = 1'b0;
				sram.we_n    = 1'b0;
				sram.data_oe = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

/* verilog/mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top import mem_pkg::*; #(
	parameter int STEP_LOG2   = 1,
	parameter int QUEUE_DEPTH = 4
) (
	input  logic      clk,
	input  logic      rst,
	input  mem_req_t  exe_req,
	input  logic      pop,
	input  mem_word_t sram_data_in,
	output sram_bus_t sram,
	output logic      exe_done,
	output mem_word_t exe_rdata,
	output mem_word_t head,
	output logic      empty
);

	mem_req_t  fetch_req;
	logic      fetch_done;
	mem_word_t fetch_rdata;
	logic      push;
	mem_word_t push_data;
	logic      full;

	// Shared SRAM, execute over fetch
	sram_ctrl #(
		.STEP_LOG2(STEP_LOG2)
	) u_sram_ctrl (
		.clk         (clk),
		.rst         (rst),
		.exe_req     (exe_req),
		.fetch_req   (fetch_req),
		.sram_data_in(sram_data_in),
		.sram        (sram),
		.exe_done    (exe_done),
		.fetch_done  (fetch_done),
		.exe_rdata   (exe_rdata),
		.fetch_rdata (fetch_rdata)
	);

	// Program counter side
	fetch_unit u_fetch_unit (
		.clk        (clk),
		.rst        (rst),
		.fetch_done (fetch_done),
		.fetch_rdata(fetch_rdata),
		.full       (full),
		.fetch_req  (fetch_req),
		.push       (push),
		.push_data  (push_data)
	);

	// Instruction words waiting for the pipeline
	fetch_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) u_fetch_queue (
		.clk      (clk),
		.rst      (rst),
		.push     (push),
		.push_data(push_data),
		.pop      (pop),
		.head     (head),
		.empty    (empty),
		.full     (full)
	);

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 4
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Reset low from time zero, released on a rising edge
	initial begin
		rst = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b1;
	end

endmodule

/* sim/sram_model.sv */
`timescale 1ns/1ps

module sram_model import mem_pkg::*; #(
	parameter int WORDS = 1024
) (
	input  mem_addr_t addr,
	input  mem_word_t data_w,
	input  logic      oe_n,
	input  logic      we_n,
	input  logic      en_n,
	output mem_word_t data_r,
	output int        write_count
);

	localparam int IDX_W = $clog2(WORDS);

	mem_word_t mem [WORDS];

	// Preload, each word is its address folded with a fixed mask
	initial begin
		for (int i = 0; i < WORDS; i++) begin
			mem[i] = mem_word_t'(i) ^ 16'ha5a5;
		end
		write_count = 0;
	end

	// Read path, only while enabled and output enabled
	assign data_r = (!en_n && !oe_n) ? mem[addr[IDX_W-1:0]] : '0;

	////////////////////
	// Write strobe
	////////////////////

	// Data is already on the bus when write enable falls
	always @(negedge we_n) begin
		if (!en_n) begin
			mem[addr[IDX_W-1:0]] <= data_w;
		end
		write_count <= write_count + 1;
	end

endmodule

/* sim/tb_mem_subsys.sv */
`timescale 1ns/1ps

module tb_mem_subsys import mem_pkg::*;;

	localparam int TIMEOUT_CYCLES = 4000;
	localparam int MEM_WORDS      = 1024;

	logic      clk;
	logic      rst;
	mem_req_t  exe_req;
	logic      pop;
	mem_word_t sram_data_in;
	sram_bus_t sram;
	logic      exe_done;
	mem_word_t exe_rdata;
	mem_word_t head;
	logic      empty;
	mem_word_t model_q;
	int        write_count;

	mem_word_t ref_mem [MEM_WORDS];
	integer    seed;
	int        cycles;
	act_tag_t  next_tag;
	logic      pop_en;
	logic      pop_take;
	int        fetch_idx;
	mem_word_t exp_head;
	logic      chk_read;
	mem_word_t exp_rdata;
	logic      hold_chk;
	int        hold_count;
	logic      bp_chk;
	logic      exe_busy;

	tb_clock #(
		.PERIOD_NS   (40),
		.RESET_CYCLES(4)
	) u_tb_clock (
		.clk(clk),
		.rst(rst)
	);

	sram_model #(
		.WORDS(MEM_WORDS)
	) u_sram_model (
		.addr       (sram.addr),
		.data_w     (sram.data_out),
		.oe_n       (sram.oe_n),
		.we_n       (sram.we_n),
		.en_n       (sram.en_n),
		.data_r     (model_q),
		.write_count(write_count)
	);

	mem_subsys_top #(
		.STEP_LOG2  (1),
		.QUEUE_DEPTH(4)
	) u_mem_subsys_top (
		.clk         (clk),
		.rst         (rst),
		.exe_req     (exe_req),
		.pop         (pop),
		.sram_data_in(sram_data_in),
		.sram        (sram),
		.exe_done    (exe_done),
		.exe_rdata   (exe_rdata),
		.head        (head),
		.empty       (empty)
	);

	// Resolved data bus
	assign sram_data_in = sram.data_oe ? sram.data_out : model_q;
	assign exp_head     = ref_mem[fetch_idx[9:0]];
	assign exe_busy     = exe_req.need && !exe_done;

	////////////////////
	// Failure reports
	////////////////////

	task automatic report_mismatch(input string test, input logic [31:0] exp,
			input logic [31:0] act);
		$display("[ERROR] %s expected %h actual %h", test, exp, act);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic report_problem(input string what);
		$display("[ERROR] %s", what);
		$display("Simulation failed");
		$fatal(1);
	endtask

	////////////////////
	// Assertions
	////////////////////

	// Sampled on the falling edge, away from the driving edge
	a_reset_idle: assert property (@(negedge clk) !rst |->
			(sram.oe_n && sram.we_n && sram.en_n && !sram.data_oe && !exe_done && empty))
		else report_problem("reset_idle: strobes, done or empty flag wrong during reset");

	a_oe_we: assert property (@(negedge clk) !(!sram.oe_n && !sram.we_n))
		else report_problem("strobes: output enable and write enable both low");

	a_bus_fight: assert property (@(negedge clk) !(sram.data_oe && !sram.oe_n))
		else report_problem("strobes: data driven while output enable is low");

	a_read_data: assert property (@(negedge clk) disable iff (!rst)
			(exe_done && chk_read) |-> (exe_rdata == exp_rdata))
		else report_mismatch("write_read", exp_rdata, exe_rdata);

	a_fetch_order: assert property (@(negedge clk) disable iff (!rst)
			(pop && !empty) |-> (head == exp_head))
		else report_mismatch("fetch_order", exp_head, head);

	a_tag_count: assert property (@(negedge clk) disable iff (!rst)
			hold_chk |-> (write_count == hold_count))
		else report_mismatch("tag_rule", hold_count, write_count);

	a_tag_done: assert property (@(negedge clk) disable iff (!rst)
			hold_chk |-> exe_done)
		else report_problem("tag_rule: done dropped while the tag was held");

	a_backpressure: assert property (@(negedge clk) disable iff (!rst)
			(bp_chk && !exe_busy) |-> sram.en_n)
		else report_problem("backpressure: SRAM enabled while the queue is full");

	////////////////////
	// Pop side
	////////////////////

	always @(posedge clk) begin
		pop <= pop_en && cycles[0];
	end

	always @(negedge clk) begin
		pop_take = pop && !empty;
	end

	always @(posedge clk) begin
		if (pop_take) begin
			fetch_idx <= fetch_idx + 1;
		end
	end

	// Run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			report_problem("timeout: run did not finish within the cycle limit");
		end
	end

	////////////////////
	// Stimulus
	////////////////////

	// Starts one access with a fresh tag and waits for its done level
	task automatic exe_access(input logic is_wr, input mem_addr_t addr,
			input mem_word_t data);
		mem_req_t r;
		r       = '0;
		r.need  = 1'b1;
		r.rd    = !is_wr;
		r.wr    = is_wr;
		r.addr  = addr;
		r.wdata = data;
		r.act   = next_tag;
		@(posedge clk);
		exe_req   <= r;
		chk_read  <= !is_wr;
		exp_rdata <= ref_mem[addr[9:0]];
		next_tag  = next_tag + 1'b1;
		@(negedge clk);
		while (!exe_done) @(negedge clk);
		if (is_wr) begin
			ref_mem[addr[9:0]] = data;
		end
	endtask

	task automatic exe_release();
		@(posedge clk);
		exe_req.need <= 1'b0;
		chk_read     <= 1'b0;
	endtask

	task automatic wait_fetched(input int count);
		while (fetch_idx < count) @(negedge clk);
	endtask

	initial begin
		mem_addr_t a;
		mem_word_t d;
		for (int i = 0; i < MEM_WORDS; i++) begin
			ref_mem[i] = mem_word_t'(i) ^ 16'ha5a5;
		end
		seed      = 32'hd65e_e833;
		exe_req   = '0;
		pop       = 1'b0;
		pop_en    = 1'b0;
		pop_take  = 1'b0;
		fetch_idx = 0;
		cycles    = 0;
		chk_read  = 1'b0;
		exp_rdata = '0;
		hold_chk  = 1'b0;
		hold_count = 0;
		bp_chk    = 1'b0;
		// Fetch tags count up from 1, execute tags live above them
		next_tag  = 8'h80;
		wait (rst);
		@(posedge clk);
		pop_en <= 1'b1;

		// Writes stay above the fetched region
		for (int i = 0; i < 10; i++) begin
			a = mem_addr_t'(512 + ($random(seed) & 511));
			d = mem_word_t'($random(seed));
			exe_access(1'b1, a, d);
			exe_release();
			exe_access(1'b0, a, '0);
			exe_release();
		end
		wait_fetched(8);

		// Queue fills with no pops
		@(posedge clk);
		pop_en <= 1'b0;
		repeat (100) @(posedge clk);
		bp_chk <= 1'b1;

		// Same tag held after a finished write
		a = mem_addr_t'(512 + ($random(seed) & 511));
		d = mem_word_t'($random(seed));
		exe_access(1'b1, a, d);
		@(posedge clk);
		hold_count <= write_count;
		hold_chk   <= 1'b1;
		repeat (40) @(posedge clk);
		hold_chk <= 1'b0;
		exe_release();
		repeat (10) @(posedge clk);
		bp_chk <= 1'b0;

		// Sequence resumes after the stall
		pop_en <= 1'b1;
		wait_fetched(fetch_idx + 12);
		@(posedge clk);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

/* compile.f */
verilog/mem_pkg.sv
verilog/fetch_queue.sv
verilog/fetch_unit.sv
verilog/sram_ctrl.sv
verilog/mem_subsys_top.sv
sim/tb_clock.sv
sim/sram_model.sv
sim/tb_mem_subsys.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f compile.f \
	--top-module tb_mem_subsys --Mdir obj_dir -o tb_mem_subsys
./obj_dir/tb_mem_subsys > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation completed successfully" sim.log; then
	exit 0
else
	exit 1
fi
